/* csr_cfg.svh */
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// csr addresses
`define CSR_CRMD        14'h000
`define CSR_PRMD        14'h001
`define CSR_ECTL        14'h004
`define CSR_ESTAT       14'h005
`define CSR_ERA         14'h006
`define CSR_BADV        14'h007
`define CSR_EENTRY      14'h00c
`define CSR_SAVE0       14'h030
`define CSR_SAVE1       14'h031
`define CSR_SAVE2       14'h032
`define CSR_SAVE3       14'h033
`define CSR_TID         14'h040
`define CSR_TCFG        14'h041
`define CSR_TVAL        14'h042
`define CSR_TICLR       14'h044

// field positions
`define CRMD_PLV        1:0
`define CRMD_IE         2
`define CRMD_DA         3
`define CRMD_PG         4
`define CRMD_DATF       6:5
`define CRMD_DATM       8:7
`define PRMD_PPLV       1:0
`define PRMD_PIE        2
`define ECTL_LIE        12:0
// bit 10 of lie has no source
`define ECTL_LIE_MASK   13'h1bff
`define ESTAT_IS        12:0
`define ESTAT_SWI       1:0
`define ESTAT_HWI       9:2
`define ESTAT_TI        11
`define ESTAT_ECODE     21:16
`define ESTAT_ESUBCODE  30:22
`define TCFG_EN         0
`define TCFG_PERIODIC   1
`define TCFG_INITVAL    31:2
`define TICLR_CLR       0
`define EENTRY_VA       31:6

// exception codes
`define ECODE_INT       6'd0
`define ECODE_ALE       6'd9
`define ECODE_SYS       6'd11
`define ECODE_BRK       6'd12
`define ECODE_INE       6'd13

// rdcnt selectors
`define RDCNT_NONE      2'd0
`define RDCNT_ID        2'd1
`define RDCNT_VLOW      2'd2
`define RDCNT_VHIGH     2'd3

`define CRMD_RESET      32'h8

`endif

/* csr_pkg.sv */
package csr_pkg;

  // csr value or write mask
  typedef logic [31:0] csr_data_t;
  typedef logic [13:0] csr_addr_t;

  typedef logic [5:0]  ecode_t;
  typedef logic [8:0]  esubcode_t;
  typedef logic [1:0]  plv_t;

  // external interrupt lines
  typedef logic [7:0]  hw_int_t;

  typedef logic [1:0]  rdcnt_t;
  typedef logic [63:0] counter_t;

endpackage

/* csr_properties.sv */
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_properties (
  input logic        clk_i,
  input logic        rst_n_i,
  input logic        stall_i,
  input logic        excp_any_i,
  input logic        irq_i,
  input logic [31:0] rd_data_i,
  input logic [1:0]  crmd_plv_i
);

  int fail_count = 0;

  property p_irq_low_after_reset;
    @(posedge clk_i) !rst_n_i |=> !irq_i;
  endproperty

  property p_rd_data_held;
    @(posedge clk_i) disable iff (!rst_n_i) stall_i |=> $stable(rd_data_i);
  endproperty

  // plv drops to kernel on every taken exception
  property p_plv_zero_after_excp;
    @(posedge clk_i) disable iff (!rst_n_i)
      (!stall_i && excp_any_i) |=> (crmd_plv_i == 2'b00);
  endproperty

  a_irq_low_after_reset: assert property (p_irq_low_after_reset)
    else begin
      $error("int_o is high in the cycle after reset");
      fail_count++;
    end

  a_rd_data_held: assert property (p_rd_data_held)
    else begin
      $error("csr_r_data_o changed across a stalled cycle");
      fail_count++;
    end

  a_plv_zero_after_excp: assert property (p_plv_zero_after_excp)
    else begin
      $error("crmd plv is not 0 after an unstalled exception");
      fail_count++;
    end

endmodule

bind csr_top csr_properties csr_properties_i (
  .clk_i      (clk),
  .rst_n_i    (rst_n),
  .stall_i    (m2_stall_i),
  .excp_any_i (excp_int_i | excp_ale_i | excp_sys_i | excp_brk_i | excp_ine_i),
  .irq_i      (int_o),
  .rd_data_i  (csr_r_data_o),
  .crmd_plv_i (csr_regs_i.crmd_q[`CRMD_PLV])
);

/* csr_regs.sv */
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_regs (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               m2_stall_i,
  input  csr_pkg::hw_int_t   int_i,
  input  csr_pkg::csr_addr_t csr_r_addr_i,
  input  csr_pkg::rdcnt_t    rdcnt_i,
  input  logic               csr_we_i,
  input  csr_pkg::csr_addr_t csr_w_addr_i,
  input  csr_pkg::csr_data_t csr_w_mask_i,
  input  csr_pkg::csr_data_t csr_w_data_i,
  csr_trap_if.dst            trap,
  input  csr_pkg::csr_data_t tcfg_i,
  input  csr_pkg::csr_data_t tval_i,
  input  logic               timer_pending_i,
  input  csr_pkg::counter_t  counter_i,
  output logic               wr_tcfg_o,
  output logic               wr_ticlr_clr_o,
  output csr_pkg::csr_data_t wr_data_o,
  output csr_pkg::csr_data_t csr_r_data_o,
  output logic               int_o
);
  import csr_pkg::*;

  csr_data_t crmd_q;
  csr_data_t prmd_q;
  csr_data_t ectl_q;
  csr_data_t era_q;
  csr_data_t badv_q;
  csr_data_t eentry_q;
  csr_data_t tid_q;
  csr_data_t save_q [4];
  logic [1:0] is_sw_q;
  hw_int_t   is_hw_q;
  hw_int_t   int_q;
  ecode_t    ecode_q;
  esubcode_t esubcode_q;
  csr_data_t estat_val;
  csr_data_t wr_data;
  csr_data_t rd_val;
  logic      csr_we;
  logic      crmd_we;
  logic      prmd_we;
  logic      ectl_we;
  logic      estat_we;
  logic      era_we;
  logic      badv_we;
  logic      eentry_we;
  logic      tid_we;
  logic [3:0] save_we;

  // mask merge against the last read data
  assign wr_data = (csr_r_data_o & ~csr_w_mask_i) | (csr_w_data_i & csr_w_mask_i);
  assign csr_we  = csr_we_i && !m2_stall_i;

  assign crmd_we    = csr_we && (csr_w_addr_i == `CSR_CRMD);
  assign prmd_we    = csr_we && (csr_w_addr_i == `CSR_PRMD);
  assign ectl_we    = csr_we && (csr_w_addr_i == `CSR_ECTL);
  assign estat_we   = csr_we && (csr_w_addr_i == `CSR_ESTAT);
  assign era_we     = csr_we && (csr_w_addr_i == `CSR_ERA);
  assign badv_we    = csr_we && (csr_w_addr_i == `CSR_BADV);
  assign eentry_we  = csr_we && (csr_w_addr_i == `CSR_EENTRY);
  assign tid_we     = csr_we && (csr_w_addr_i == `CSR_TID);
  assign save_we[0] = csr_we && (csr_w_addr_i == `CSR_SAVE0);
  assign save_we[1] = csr_we && (csr_w_addr_i == `CSR_SAVE1);
  assign save_we[2] = csr_we && (csr_w_addr_i == `CSR_SAVE2);
  assign save_we[3] = csr_we && (csr_w_addr_i == `CSR_SAVE3);

  // timer write bus
  assign wr_tcfg_o      = csr_we && (csr_w_addr_i == `CSR_TCFG);
  assign wr_ticlr_clr_o = csr_we && (csr_w_addr_i == `CSR_TICLR) && wr_data[`TICLR_CLR];
  assign wr_data_o      = wr_data;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      crmd_q <= `CRMD_RESET;
    end else if (trap.excp_valid) begin
      crmd_q[`CRMD_PLV] <= '0;
      crmd_q[`CRMD_IE]  <= 1'b0;
    end else if (trap.ertn_valid) begin
      crmd_q[`CRMD_PLV] <= prmd_q[`PRMD_PPLV];
      crmd_q[`CRMD_IE]  <= prmd_q[`PRMD_PIE];
    end else if (crmd_we) begin
      crmd_q[`CRMD_PLV]  <= wr_data[`CRMD_PLV];
      crmd_q[`CRMD_IE]   <= wr_data[`CRMD_IE];
      crmd_q[`CRMD_DA]   <= wr_data[`CRMD_DA];
      crmd_q[`CRMD_PG]   <= wr_data[`CRMD_PG];
      crmd_q[`CRMD_DATF] <= wr_data[`CRMD_DATF];
      crmd_q[`CRMD_DATM] <= wr_data[`CRMD_DATM];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prmd_q <= '0;
    end else if (trap.excp_valid) begin
      prmd_q[`PRMD_PPLV] <= crmd_q[`CRMD_PLV];
      prmd_q[`PRMD_PIE]  <= crmd_q[`CRMD_IE];
    end else if (prmd_we) begin
      prmd_q[`PRMD_PPLV] <= wr_data[`PRMD_PPLV];
      prmd_q[`PRMD_PIE]  <= wr_data[`PRMD_PIE];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ectl_q <= '0;
    end else if (ectl_we) begin
      ectl_q[`ECTL_LIE] <= wr_data[`ECTL_LIE] & `ECTL_LIE_MASK;
    end
  end

  // hw lines: one register stage, then into is
  always_ff @(posedge clk) begin
    int_q <= int_i;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      is_sw_q    <= '0;
      is_hw_q    <= '0;
      ecode_q    <= '0;
      esubcode_q <= '0;
    end else begin
      is_hw_q <= int_q;
      if (trap.excp_valid) begin
        ecode_q    <= trap.ecode;
        esubcode_q <= trap.esubcode;
      end
      if (estat_we) begin
        is_sw_q <= wr_data[`ESTAT_SWI];
      end
    end
  end

  always_comb begin
    estat_val                  = '0;
    estat_val[`ESTAT_SWI]      = is_sw_q;
    estat_val[`ESTAT_HWI]      = is_hw_q;
    estat_val[`ESTAT_TI]       = timer_pending_i;
    estat_val[`ESTAT_ECODE]    = ecode_q;
    estat_val[`ESTAT_ESUBCODE] = esubcode_q;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      era_q  <= '0;
      badv_q <= '0;
    end else begin
      if (trap.excp_valid) begin
        era_q <= trap.era;
      end else if (era_we) begin
        era_q <= wr_data;
      end
      if (trap.excp_valid && trap.badv_we) begin
        badv_q <= trap.badv;
      end else if (badv_we) begin
        badv_q <= wr_data;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      eentry_q <= '0;
      tid_q    <= '0;
    end else begin
      if (eentry_we) begin
        eentry_q[`EENTRY_VA] <= wr_data[`EENTRY_VA];
      end
      if (tid_we) begin
        tid_q <= wr_data;
      end
    end
  end

  for (genvar i = 0; i < 4; i++) begin : g_save
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        save_q[i] <= '0;
      end else if (save_we[i]) begin
        save_q[i] <= wr_data;
      end
    end
  end

  always_comb begin
    rd_val = '0;
    case (rdcnt_i)
      `RDCNT_ID:    rd_val = tid_q;
      `RDCNT_VLOW:  rd_val = counter_i[31:0];
      `RDCNT_VHIGH: rd_val = counter_i[63:32];
      `RDCNT_NONE: begin
        case (csr_r_addr_i)
          `CSR_CRMD:   rd_val = crmd_q;
          `CSR_PRMD:   rd_val = prmd_q;
          `CSR_ECTL:   rd_val = ectl_q;
          `CSR_ESTAT:  rd_val = estat_val;
          `CSR_ERA:    rd_val = era_q;
          `CSR_BADV:   rd_val = badv_q;
          `CSR_EENTRY: rd_val = eentry_q;
          `CSR_SAVE0:  rd_val = save_q[0];
          `CSR_SAVE1:  rd_val = save_q[1];
          `CSR_SAVE2:  rd_val = save_q[2];
          `CSR_SAVE3:  rd_val = save_q[3];
          `CSR_TID:    rd_val = tid_q;
          `CSR_TCFG:   rd_val = tcfg_i;
          `CSR_TVAL:   rd_val = tval_i;
          default:     rd_val = '0;
        endcase
      end
      default: rd_val = '0;
    endcase
  end

  // read data is held under stall
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      csr_r_data_o <= '0;
    end else if (!m2_stall_i) begin
      csr_r_data_o <= rd_val;
    end
  end

  assign int_o = crmd_q[`CRMD_IE] && (|(estat_val[`ESTAT_IS] & ectl_q[`ECTL_LIE]));

endmodule

/* csr_tb.sv */
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_tb;
  import csr_pkg::*;

  // the tests run for roughly 300 cycles
  localparam int MAX_CYCLES = 2000;

  logic      clk;
  logic      rst_n;
  hw_int_t   int_i;
  logic      excp_int_i;
  logic      excp_ale_i;
  logic      excp_sys_i;
  logic      excp_brk_i;
  logic      excp_ine_i;
  logic      ertn_i;
  logic      m2_stall_i;
  csr_data_t pc_i;
  csr_data_t vaddr_i;
  csr_addr_t csr_r_addr_i;
  rdcnt_t    rdcnt_i;
  logic      csr_we_i;
  csr_addr_t csr_w_addr_i;
  csr_data_t csr_w_mask_i;
  csr_data_t csr_w_data_i;
  csr_data_t csr_r_data_o;
  logic      int_o;

  integer    seed;
  int        cycles;
  int        checks;
  int        errors;
  int        test_errors;
  csr_data_t exp_save [4];
  csr_data_t exp_tid;
  csr_data_t exp_era;
  csr_data_t exp_badv;
  csr_data_t exp_crmd;
  ecode_t    exp_ecode;

  tb_clk_gen clk_gen_i (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  csr_top csr_top_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .int_i        (int_i),
    .excp_int_i   (excp_int_i),
    .excp_ale_i   (excp_ale_i),
    .excp_sys_i   (excp_sys_i),
    .excp_brk_i   (excp_brk_i),
    .excp_ine_i   (excp_ine_i),
    .ertn_i       (ertn_i),
    .m2_stall_i   (m2_stall_i),
    .pc_i         (pc_i),
    .vaddr_i      (vaddr_i),
    .csr_r_addr_i (csr_r_addr_i),
    .rdcnt_i      (rdcnt_i),
    .csr_we_i     (csr_we_i),
    .csr_w_addr_i (csr_w_addr_i),
    .csr_w_mask_i (csr_w_mask_i),
    .csr_w_data_i (csr_w_data_i),
    .csr_r_data_o (csr_r_data_o),
    .int_o        (int_o)
  );

  task automatic check_eq(input string name, input csr_data_t got, input csr_data_t exp);
    checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic end_test(input string name);
    if (test_errors == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d checks failed", name, test_errors);
    end
    test_errors = 0;
  endtask

  // one cycle latency, data taken at the negedge after the sampling edge
  task automatic read_port(input csr_addr_t addr, input rdcnt_t sel, output csr_data_t data);
    @(posedge clk);
    csr_r_addr_i <= addr;
    rdcnt_i      <= sel;
    @(posedge clk);
    @(negedge clk);
    data = csr_r_data_o;
  endtask

  task automatic write_csr(input csr_addr_t addr, input csr_data_t mask, input csr_data_t data);
    @(posedge clk);
    csr_we_i     <= 1'b1;
    csr_w_addr_i <= addr;
    csr_w_mask_i <= mask;
    csr_w_data_i <= data;
    @(posedge clk);
    csr_we_i <= 1'b0;
    @(negedge clk);
  endtask

  // req bits are int, ale, sys, brk, ine from bit 0 up
  task automatic raise_excp(input logic [4:0] req, input csr_data_t pc, input csr_data_t va);
    @(posedge clk);
    excp_int_i <= req[0];
    excp_ale_i <= req[1];
    excp_sys_i <= req[2];
    excp_brk_i <= req[3];
    excp_ine_i <= req[4];
    pc_i       <= pc;
    vaddr_i    <= va;
    @(posedge clk);
    excp_int_i <= 1'b0;
    excp_ale_i <= 1'b0;
    excp_sys_i <= 1'b0;
    excp_brk_i <= 1'b0;
    excp_ine_i <= 1'b0;
    @(negedge clk);
  endtask

  task automatic return_from_excp();
    @(posedge clk);
    ertn_i <= 1'b1;
    @(posedge clk);
    ertn_i <= 1'b0;
    @(negedge clk);
  endtask

  function automatic ecode_t cause_of(input logic [4:0] req);
    if (req[0]) begin
      return `ECODE_INT;
    end else if (req[1]) begin
      return `ECODE_ALE;
    end else if (req[2]) begin
      return `ECODE_SYS;
    end else if (req[3]) begin
      return `ECODE_BRK;
    end
    return `ECODE_INE;
  endfunction

  task automatic reset_rw_test();
    csr_addr_t zero_addrs [13];
    csr_addr_t save_addrs [4];
    csr_data_t rd;
    csr_data_t d;
    csr_data_t mask;
    csr_data_t eentry_exp;
    zero_addrs = '{`CSR_PRMD, `CSR_ECTL, `CSR_ESTAT, `CSR_ERA, `CSR_BADV, `CSR_EENTRY,
                   `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3, `CSR_TID, `CSR_TCFG,
                   `CSR_TVAL};
    save_addrs = '{`CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3};
    check_eq("csr_r_data_o", csr_r_data_o, '0);
    check_eq("int_o", {31'd0, int_o}, '0);
    read_port(`CSR_CRMD, `RDCNT_NONE, rd);
    check_eq("crmd", rd, `CRMD_RESET);
    foreach (zero_addrs[i]) begin
      read_port(zero_addrs[i], `RDCNT_NONE, rd);
      check_eq($sformatf("csr %h", zero_addrs[i]), rd, '0);
    end
    foreach (save_addrs[i]) begin
      d = $random(seed);
      exp_save[i] = d;
      write_csr(save_addrs[i], '1, d);
    end
    exp_tid = $random(seed);
    write_csr(`CSR_TID, '1, exp_tid);
    d = $random(seed);
    write_csr(`CSR_EENTRY, '1, d);
    // only the va field is kept
    eentry_exp = '0;
    eentry_exp[`EENTRY_VA] = d[`EENTRY_VA];
    foreach (save_addrs[i]) begin
      read_port(save_addrs[i], `RDCNT_NONE, rd);
      check_eq($sformatf("save%0d", i), rd, exp_save[i]);
    end
    read_port(`CSR_TID, `RDCNT_NONE, rd);
    check_eq("tid", rd, exp_tid);
    read_port(`CSR_EENTRY, `RDCNT_NONE, rd);
    check_eq("eentry", rd, eentry_exp);
    // partial mask merges with the last read data of save1
    read_port(`CSR_SAVE1, `RDCNT_NONE, rd);
    d = $random(seed);
    mask = 32'h00ff_ff00;
    write_csr(`CSR_SAVE1, mask, d);
    exp_save[1] = (exp_save[1] & ~mask) | (d & mask);
    read_port(`CSR_SAVE1, `RDCNT_NONE, rd);
    check_eq("save1 merged", rd, exp_save[1]);
    end_test("reset and read/write");
  endtask

  task automatic excp_test();
    logic [4:0] reqs [8];
    csr_data_t  pc;
    csr_data_t  va;
    csr_data_t  rd;
    csr_data_t  crmd_exp;
    csr_data_t  prmd_exp;
    reqs = '{5'b00001, 5'b00010, 5'b00100, 5'b01000, 5'b10000,
             5'b11110, 5'b11100, 5'b11000};
    exp_crmd = `CRMD_RESET;
    exp_crmd[`CRMD_PLV] = 2'd3;
    exp_crmd[`CRMD_IE] = 1'b1;
    write_csr(`CSR_CRMD, '1, exp_crmd);
    foreach (reqs[i]) begin
      pc = $random(seed);
      va = $random(seed);
      raise_excp(reqs[i], pc, va);
      exp_era = pc;
      exp_ecode = cause_of(reqs[i]);
      if (exp_ecode == `ECODE_ALE) begin
        exp_badv = va;
      end
      crmd_exp = exp_crmd;
      crmd_exp[`CRMD_PLV] = 2'd0;
      crmd_exp[`CRMD_IE] = 1'b0;
      prmd_exp = '0;
      prmd_exp[`PRMD_PPLV] = exp_crmd[`CRMD_PLV];
      prmd_exp[`PRMD_PIE] = exp_crmd[`CRMD_IE];
      read_port(`CSR_CRMD, `RDCNT_NONE, rd);
      check_eq("crmd after exception", rd, crmd_exp);
      read_port(`CSR_PRMD, `RDCNT_NONE, rd);
      check_eq("prmd", rd, prmd_exp);
      read_port(`CSR_ERA, `RDCNT_NONE, rd);
      check_eq("era", rd, exp_era);
      read_port(`CSR_ESTAT, `RDCNT_NONE, rd);
      check_eq("estat.ecode", {26'd0, rd[`ESTAT_ECODE]}, {26'd0, exp_ecode});
      read_port(`CSR_BADV, `RDCNT_NONE, rd);
      check_eq("badv", rd, exp_badv);
      return_from_excp();
      read_port(`CSR_CRMD, `RDCNT_NONE, rd);
      check_eq("crmd after ertn", rd, exp_crmd);
    end
    end_test("exception and ertn");
  endtask

  task automatic stall_test();
    csr_data_t held;
    csr_data_t rd;
    read_port(`CSR_SAVE2, `RDCNT_NONE, held);
    check_eq("save2", held, exp_save[2]);
    @(posedge clk);
    m2_stall_i   <= 1'b1;
    csr_r_addr_i <= `CSR_CRMD;
    csr_we_i     <= 1'b1;
    csr_w_addr_i <= `CSR_SAVE2;
    csr_w_mask_i <= '1;
    csr_w_data_i <= ~held;
    excp_sys_i   <= 1'b1;
    pc_i         <= ~exp_era;
    repeat (3) begin
      @(negedge clk);
      check_eq("csr_r_data_o under stall", csr_r_data_o, held);
    end
    @(posedge clk);
    m2_stall_i <= 1'b0;
    csr_we_i   <= 1'b0;
    excp_sys_i <= 1'b0;
    read_port(`CSR_SAVE2, `RDCNT_NONE, rd);
    check_eq("save2 after stall", rd, exp_save[2]);
    read_port(`CSR_ERA, `RDCNT_NONE, rd);
    check_eq("era after stall", rd, exp_era);
    read_port(`CSR_CRMD, `RDCNT_NONE, rd);
    check_eq("crmd after stall", rd, exp_crmd);
    read_port(`CSR_ESTAT, `RDCNT_NONE, rd);
    check_eq("estat.ecode after stall", {26'd0, rd[`ESTAT_ECODE]}, {26'd0, exp_ecode});
    end_test("stall");
  endtask

  task automatic timer_test();
    csr_data_t tcfg_val;
    csr_data_t ticlr_val;
    csr_data_t tval_m;
    csr_data_t tval_prev;
    csr_data_t rd;
    logic      pend;
    logic      pend_prev;
    int        clr_edge;
    int        k;
    tcfg_val = '0;
    tcfg_val[`TCFG_INITVAL] = 30'd3;
    tcfg_val[`TCFG_PERIODIC] = 1'b1;
    tcfg_val[`TCFG_EN] = 1'b1;
    ticlr_val = '0;
    ticlr_val[`TICLR_CLR] = 1'b1;
    clr_edge = 18;
    pend = 1'b0;
    tval_m = {tcfg_val[`TCFG_INITVAL], 2'b00};
    @(posedge clk);
    csr_r_addr_i <= `CSR_ESTAT;
    rdcnt_i      <= `RDCNT_NONE;
    csr_we_i     <= 1'b1;
    csr_w_addr_i <= `CSR_TCFG;
    csr_w_mask_i <= '1;
    csr_w_data_i <= tcfg_val;
    // edge w
    @(posedge clk);
    csr_we_i <= 1'b0;
    for (k = 1; k <= 30; k++) begin
      @(posedge clk);
      pend_prev = pend;
      tval_prev = tval_m;
      // model state after edge w+k
      if (k == clr_edge) begin
        pend = 1'b0;
      end else if (tval_m == '0) begin
        pend = 1'b1;
      end
      if (tval_m == '0) begin
        tval_m = {tcfg_val[`TCFG_INITVAL], 2'b00};
      end else begin
        tval_m = tval_m - 32'd1;
      end
      if (k == clr_edge - 1) begin
        csr_we_i     <= 1'b1;
        csr_w_addr_i <= `CSR_TICLR;
        csr_w_data_i <= ticlr_val;
      end else if (k == clr_edge) begin
        csr_we_i <= 1'b0;
      end
      if (k == 26) begin
        csr_r_addr_i <= `CSR_TVAL;
      end
      @(negedge clk);
      if (k <= 26) begin
        check_eq($sformatf("estat.ti after edge w+%0d", k),
                 {31'd0, csr_r_data_o[`ESTAT_TI]}, {31'd0, pend_prev});
      end else begin
        check_eq($sformatf("tval after edge w+%0d", k), csr_r_data_o, tval_prev);
      end
    end
    write_csr(`CSR_TCFG, '1, '0);
    write_csr(`CSR_TICLR, '1, ticlr_val);
    read_port(`CSR_ESTAT, `RDCNT_NONE, rd);
    check_eq("estat.ti after clear", {31'd0, rd[`ESTAT_TI]}, '0);
    end_test("timer");
  endtask

  task automatic irq_test();
    csr_data_t crmd_no_ie;
    crmd_no_ie = exp_crmd;
    crmd_no_ie[`CRMD_IE] = 1'b0;
    write_csr(`CSR_CRMD, '1, exp_crmd);
    // lie bit 0 enables software interrupt 0
    write_csr(`CSR_ECTL, '1, 32'h1);
    check_eq("int_o before swi", {31'd0, int_o}, '0);
    write_csr(`CSR_ESTAT, '1, 32'h1);
    check_eq("int_o with swi", {31'd0, int_o}, 32'd1);
    write_csr(`CSR_CRMD, '1, crmd_no_ie);
    check_eq("int_o with ie clear", {31'd0, int_o}, '0);
    write_csr(`CSR_ESTAT, '1, '0);
    write_csr(`CSR_CRMD, '1, exp_crmd);
    // hw line 3 lands on is bit 5
    write_csr(`CSR_ECTL, '1, 32'h1 << 5);
    check_eq("int_o before hw line", {31'd0, int_o}, '0);
    @(posedge clk);
    int_i <= 8'h08;
    @(posedge clk);
    @(negedge clk);
    check_eq("int_o one edge after int_i", {31'd0, int_o}, '0);
    @(posedge clk);
    @(negedge clk);
    check_eq("int_o two edges after int_i", {31'd0, int_o}, 32'd1);
    @(posedge clk);
    int_i <= '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_eq("int_o after int_i low", {31'd0, int_o}, '0);
    write_csr(`CSR_ECTL, '1, '0);
    end_test("interrupt request");
  endtask

  task automatic counter_test();
    csr_data_t v1;
    csr_data_t v2;
    csr_data_t rd;
    int        n;
    read_port(`CSR_CRMD, `RDCNT_VLOW, v1);
    n = 5 + ($random(seed) & 15);
    repeat (n) @(negedge clk);
    v2 = csr_r_data_o;
    check_eq("rdcnt vlow delta", v2 - v1, csr_data_t'(n));
    read_port(`CSR_CRMD, `RDCNT_VHIGH, rd);
    check_eq("rdcnt vhigh", rd, '0);
    read_port(`CSR_CRMD, `RDCNT_ID, rd);
    check_eq("rdcnt id", rd, exp_tid);
    @(posedge clk);
    rdcnt_i <= `RDCNT_NONE;
    end_test("stable counter");
  endtask

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    int_i        = '0;
    excp_int_i   = 1'b0;
    excp_ale_i   = 1'b0;
    excp_sys_i   = 1'b0;
    excp_brk_i   = 1'b0;
    excp_ine_i   = 1'b0;
    ertn_i       = 1'b0;
    m2_stall_i   = 1'b0;
    pc_i         = '0;
    vaddr_i      = '0;
    csr_r_addr_i = '0;
    rdcnt_i      = `RDCNT_NONE;
    csr_we_i     = 1'b0;
    csr_w_addr_i = '0;
    csr_w_mask_i = '0;
    csr_w_data_i = '0;
    seed         = 32'h6264;
    checks       = 0;
    errors       = 0;
    test_errors  = 0;
    exp_badv     = '0;
    wait (rst_n === 1'b1);
    @(negedge clk);
    reset_rw_test();
    excp_test();
    stall_test();
    timer_test();
    irq_test();
    counter_test();
    $display("%0d checks run, %0d failed, %0d assertion failures", checks, errors,
             csr_top_i.csr_properties_i.fail_count);
    if (errors == 0 && csr_top_i.csr_properties_i.fail_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* csr_top.sv */
`timescale 1ns/1ps

module csr_top (
  input  logic               clk,
  input  logic               rst_n,
  input  csr_pkg::hw_int_t   int_i,
  input  logic               excp_int_i,
  input  logic               excp_ale_i,
  input  logic               excp_sys_i,
  input  logic               excp_brk_i,
  input  logic               excp_ine_i,
  input  logic               ertn_i,
  input  logic               m2_stall_i,
  input  csr_pkg::csr_data_t pc_i,
  input  csr_pkg::csr_data_t vaddr_i,
  input  csr_pkg::csr_addr_t csr_r_addr_i,
  input  csr_pkg::rdcnt_t    rdcnt_i,
  input  logic               csr_we_i,
  input  csr_pkg::csr_addr_t csr_w_addr_i,
  input  csr_pkg::csr_data_t csr_w_mask_i,
  input  csr_pkg::csr_data_t csr_w_data_i,
  output csr_pkg::csr_data_t csr_r_data_o,
  output logic               int_o
);
  import csr_pkg::*;

  logic      wr_tcfg;
  logic      wr_ticlr_clr;
  csr_data_t wr_data;
  csr_data_t tcfg;
  csr_data_t tval;
  logic      timer_pending;
  counter_t  counter;

  csr_trap_if trap ();

  trap_unit trap_unit_i (
    .m2_stall_i (m2_stall_i),
    .excp_int_i (excp_int_i),
    .excp_ale_i (excp_ale_i),
    .excp_sys_i (excp_sys_i),
    .excp_brk_i (excp_brk_i),
    .excp_ine_i (excp_ine_i),
    .ertn_i     (ertn_i),
    .pc_i       (pc_i),
    .vaddr_i    (vaddr_i),
    .trap       (trap.src)
  );

  timer_unit timer_unit_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .wr_tcfg         (wr_tcfg),
    .wr_ticlr_clr    (wr_ticlr_clr),
    .wr_data         (wr_data),
    .tcfg_o          (tcfg),
    .tval_o          (tval),
    .timer_pending_o (timer_pending),
    .counter_o       (counter)
  );

  csr_regs csr_regs_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .m2_stall_i      (m2_stall_i),
    .int_i           (int_i),
    .csr_r_addr_i    (csr_r_addr_i),
    .rdcnt_i         (rdcnt_i),
    .csr_we_i        (csr_we_i),
    .csr_w_addr_i    (csr_w_addr_i),
    .csr_w_mask_i    (csr_w_mask_i),
    .csr_w_data_i    (csr_w_data_i),
    .trap            (trap.dst),
    .tcfg_i          (tcfg),
    .tval_i          (tval),
    .timer_pending_i (timer_pending),
    .counter_i       (counter),
    .wr_tcfg_o       (wr_tcfg),
    .wr_ticlr_clr_o  (wr_ticlr_clr),
    .wr_data_o       (wr_data),
    .csr_r_data_o    (csr_r_data_o),
    .int_o           (int_o)
  );

endmodule

/* csr_trap_if.sv */
`timescale 1ns/1ps

interface csr_trap_if;
  import csr_pkg::*;

  logic      excp_valid;
  logic      ertn_valid;
  ecode_t    ecode;
  esubcode_t esubcode;
  csr_data_t era;
  logic      badv_we;
  csr_data_t badv;

  modport src (
    output excp_valid,
    output ertn_valid,
    output ecode,
    output esubcode,
    output era,
    output badv_we,
    output badv
  );

  modport dst (
    input excp_valid,
    input ertn_valid,
    input ecode,
    input esubcode,
    input era,
    input badv_we,
    input badv
  );

endinterface

/* sim.f */
+incdir+.
csr_pkg.sv
csr_trap_if.sv
trap_unit.sv
timer_unit.sv
csr_regs.sv
csr_top.sv
tb_clk_gen.sv
csr_properties.sv
csr_tb.sv

/* tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // reset held over two rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

/* timer_unit.sv */
`timescale 1ns/1ps
`include "csr_cfg.svh"

module timer_unit (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               wr_tcfg,
  input  logic               wr_ticlr_clr,
  input  csr_pkg::csr_data_t wr_data,
  output csr_pkg::csr_data_t tcfg_o,
  output csr_pkg::csr_data_t tval_o,
  output logic               timer_pending_o,
  output csr_pkg::counter_t  counter_o
);
  import csr_pkg::*;

  csr_data_t tcfg_q;
  csr_data_t tval_q;
  csr_data_t reload_val;
  logic      timer_en;
  logic      timer_fire;
  logic      pending_q;
  counter_t  counter_q;

  assign timer_fire = timer_en && (tval_q == '0);
  assign reload_val = {tcfg_q[`TCFG_INITVAL], 2'b00};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tcfg_q <= '0;
    end else if (wr_tcfg) begin
      tcfg_q[`TCFG_EN]       <= wr_data[`TCFG_EN];
      tcfg_q[`TCFG_PERIODIC] <= wr_data[`TCFG_PERIODIC];
      tcfg_q[`TCFG_INITVAL]  <= wr_data[`TCFG_INITVAL];
    end
  end

  // countdown, initval counts in units of four cycles
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tval_q   <= '0;
      timer_en <= 1'b0;
    end else if (wr_tcfg) begin
      tval_q   <= {wr_data[`TCFG_INITVAL], 2'b00};
      timer_en <= wr_data[`TCFG_EN];
    end else if (timer_fire) begin
      if (tcfg_q[`TCFG_PERIODIC]) begin
        tval_q <= reload_val;
      end else begin
        // one-shot parks at all ones
        tval_q   <= '1;
        timer_en <= 1'b0;
      end
    end else if (timer_en) begin
      tval_q <= tval_q - 32'd1;
    end
  end

  // clear wins over a new fire
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending_q <= 1'b0;
    end else if (wr_ticlr_clr) begin
      pending_q <= 1'b0;
    end else if (timer_fire) begin
      pending_q <= 1'b1;
    end
  end

  // stable counter for rdcnt
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      counter_q <= '0;
    end else begin
      counter_q <= counter_q + 64'd1;
    end
  end

  assign tcfg_o          = tcfg_q;
  assign tval_o          = tval_q;
  assign timer_pending_o = pending_q;
  assign counter_o       = counter_q;

endmodule

/* trap_unit.sv */
`timescale 1ns/1ps
`include "csr_cfg.svh"

module trap_unit (
  input  logic               m2_stall_i,
  input  logic               excp_int_i,
  input  logic               excp_ale_i,
  input  logic               excp_sys_i,
  input  logic               excp_brk_i,
  input  logic               excp_ine_i,
  input  logic               ertn_i,
  input  csr_pkg::csr_data_t pc_i,
  input  csr_pkg::csr_data_t vaddr_i,
  csr_trap_if.src            trap
);

  logic int_v;
  logic ale_v;
  logic sys_v;
  logic brk_v;
  logic ine_v;
  logic excp_any;

  // nothing is taken while m2 is held
  assign int_v = !m2_stall_i && excp_int_i;
  assign ale_v = !m2_stall_i && excp_ale_i;
  assign sys_v = !m2_stall_i && excp_sys_i;
  assign brk_v = !m2_stall_i && excp_brk_i;
  assign ine_v = !m2_stall_i && excp_ine_i;

  assign excp_any = int_v || ale_v || sys_v || brk_v || ine_v;

  assign trap.excp_valid = excp_any;
  // exception blocks ertn
  assign trap.ertn_valid = !m2_stall_i && ertn_i && !excp_any;

  always_comb begin
    trap.ecode   = `ECODE_INT;
    trap.badv_we = 1'b0;
    if (int_v) begin
      trap.ecode = `ECODE_INT;
    end else if (ale_v) begin
      trap.ecode   = `ECODE_ALE;
      trap.badv_we = 1'b1;
    end else if (sys_v) begin
      trap.ecode = `ECODE_SYS;
    end else if (brk_v) begin
      trap.ecode = `ECODE_BRK;
    end else if (ine_v) begin
      trap.ecode = `ECODE_INE;
    end
  end

  // no kept cause has a sub-code
  assign trap.esubcode = '0;
  assign trap.era      = pc_i;
  assign trap.badv     = vaddr_i;

endmodule
